// File: dbxjoy_config.svh
`ifndef DBXJOY_CONFIG_SVH
`define DBXJOY_CONFIG_SVH

// Clock enable fires once every 2**DBX_CEN_BITS clocks
`define DBX_CEN_BITS 4

// Data bits in the Neo Geo chain, 12 per pad, player 0 shifted out first
// The reader clocks one extra bit on top of these as the presence sentinel
`define DBX_NEO_BITS 24

// Width of an active-high pad word inside the design
// Bits are right, left, down, up, b1..b5, coin, start, mode
`define DBX_JOY_W 12

`endif

// File: dbxjoy_pkg.sv
`default_nettype none

// Shared types for the joystick front end
package dbxjoy_pkg;

    // ====================
    // Reader sequencers
    // ====================

    // DB9 reader walks player 0 then player 1 through both select phases
    typedef enum logic [2:0] {
        db9_idle,
        db9_hi_settle,
        db9_hi_sample,
        db9_lo_settle,
        db9_lo_sample,
        db9_next
    } db9_state_t;

    // DB15 reader loads the chain once and then clocks it out bit by bit
    typedef enum logic [1:0] {
        db15_idle,
        db15_load,
        db15_clk_lo,
        db15_clk_hi
    } db15_state_t;

    // Which reader currently owns the shared user port
    typedef enum logic [0:0] {
        scan_db9,
        scan_db15
    } scan_sel_t;

endpackage

`default_nettype wire

// File: db9_reader.sv
`timescale 1ns/1ns
`default_nettype none
`include "dbxjoy_config.svh"

// Reads two three-button Mega Drive pads through a DB9 splitter
// split picks the player and sel picks which half of the pad answers
module db9_reader (
    input  logic                  rst,
    input  logic                  clk,
    input  logic                  cen,
    input  logic                  scan_en,
    input  logic [5:0]            din,
    output logic                  split,
    output logic                  sel,
    output logic                  hooked,
    output logic                  sample,
    output logic [`DBX_JOY_W-1:0] joy0,
    output logic [`DBX_JOY_W-1:0] joy1
);
    import dbxjoy_pkg::*;

    // din order is up, down, left, right, B, C and every pin is active low
    db9_state_t              state;
    logic [`DBX_JOY_W-1:0]   work;
    logic [`DBX_JOY_W-1:0]   pad0;
    logic                    pres_cur;
    logic                    pres0;

    // ====================
    // Read sequencer
    // ====================

    // The split register doubles as the current player number during a read
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= db9_idle;
            split  <= 1'b1;
            sel    <= 1'b1;
            hooked <= 1'b0;
            sample <= 1'b0;
            joy0   <= '0;
            joy1   <= '0;
        end else begin
            sample <= 1'b0;
            if (!scan_en) begin
                // Port belongs to the other reader so park with all pins high
                state <= db9_idle;
                split <= 1'b1;
                sel   <= 1'b1;
            end else if (cen) begin
                case (state)
                    db9_idle: begin
                        split <= 1'b0;
                        sel   <= 1'b1;
                        state <= db9_hi_settle;
                    end
                    db9_hi_settle: state <= db9_hi_sample;
                    db9_hi_sample: begin
                        // With sel high the pad gives directions, B and C
                        work[`DBX_JOY_W-1:6] <= '0;
                        work[5:0] <= {~din[0], ~din[1], ~din[5], ~din[4], ~din[3], ~din[2]};
                        sel   <= 1'b0;
                        state <= db9_lo_settle;
                    end
                    db9_lo_settle: state <= db9_lo_sample;
                    db9_lo_sample: begin
                        // A lands on button 3 and start on bit 10
                        work[6]  <= ~din[1];
                        work[10] <= ~din[0];
                        // A real pad pulls left and right low in this phase
                        pres_cur <= ~din[3] & ~din[2];
                        sel      <= 1'b1;
                        state    <= db9_next;
                    end
                    db9_next: begin
                        if (!split) begin
                            pad0  <= work;
                            pres0 <= pres_cur;
                            split <= 1'b1;
                            state <= db9_hi_settle;
                        end else begin
                            // Both players done, publish and hold until the next round
                            joy0   <= pad0;
                            joy1   <= work;
                            hooked <= pres0 | pres_cur;
                            sample <= 1'b1;
                            state  <= db9_idle;
                        end
                    end
                    default: state <= db9_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: db15_reader.sv
`timescale 1ns/1ns
`default_nettype none
`include "dbxjoy_config.svh"

// Reads two Neo Geo pads held in the shift-register chain of a DB15 adapter
module db15_reader (
    input  logic                  rst,
    input  logic                  clk,
    input  logic                  cen,
    input  logic                  scan_en,
    input  logic                  din,
    output logic                  loadb,
    output logic                  joy_clk,
    output logic                  hooked,
    output logic                  sample,
    output logic [`DBX_JOY_W-1:0] joy0,
    output logic [`DBX_JOY_W-1:0] joy1
);
    import dbxjoy_pkg::*;

    // One count per data bit plus the sentinel
    localparam int CNT_W = $clog2(`DBX_NEO_BITS + 2);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DBX_NEO_BITS + 1);

    db15_state_t              state;
    logic [CNT_W-1:0]         bit_cnt;
    // First bit out ends in bit 0, the sentinel ends on top
    logic [`DBX_NEO_BITS:0]   shreg;

    // ====================
    // Chain sequencer
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= db15_idle;
            loadb   <= 1'b1;
            joy_clk <= 1'b1;
            bit_cnt <= '0;
            hooked  <= 1'b0;
            sample  <= 1'b0;
            joy0    <= '0;
            joy1    <= '0;
        end else begin
            sample <= 1'b0;
            if (!scan_en) begin
                state   <= db15_idle;
                loadb   <= 1'b1;
                joy_clk <= 1'b1;
            end else if (cen) begin
                case (state)
                    db15_idle: begin
                        // Parallel load lasts one full cen period
                        loadb   <= 1'b0;
                        joy_clk <= 1'b0;
                        bit_cnt <= '0;
                        state   <= db15_load;
                    end
                    db15_load: begin
                        loadb <= 1'b1;
                        state <= db15_clk_lo;
                    end
                    db15_clk_lo: begin
                        // Take din as it stands just before the rising edge
                        joy_clk <= 1'b1;
                        shreg   <= {din, shreg[`DBX_NEO_BITS:1]};
                        bit_cnt <= bit_cnt + CNT_W'(1);
                        state   <= db15_clk_hi;
                    end
                    db15_clk_hi: begin
                        joy_clk <= 1'b0;
                        if (bit_cnt == CNT_LAST) begin
                            joy0   <= ~shreg[`DBX_JOY_W-1:0];
                            joy1   <= ~shreg[2*`DBX_JOY_W-1:`DBX_JOY_W];
                            // Adapter drives the sentinel low, an empty port floats high
                            hooked <= ~shreg[`DBX_NEO_BITS];
                            sample <= 1'b1;
                            state  <= db15_idle;
                        end else begin
                            state <= db15_clk_lo;
                        end
                    end
                    default: state <= db15_idle;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: joy_merge.sv
`timescale 1ns/1ns
`default_nettype none
`include "dbxjoy_config.svh"

// Picks the reader with hardware attached and packs it into core joystick words
module joy_merge (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  db9_hooked,
    input  logic                  db15_hooked,
    input  logic [`DBX_JOY_W-1:0] db9_joy0,
    input  logic [`DBX_JOY_W-1:0] db9_joy1,
    input  logic [`DBX_JOY_W-1:0] db15_joy0,
    input  logic [`DBX_JOY_W-1:0] db15_joy1,
    input  logic [15:0]           usb0,
    input  logic [15:0]           usb1,
    output logic [15:0]           joystick_0,
    output logic [15:0]           joystick_1,
    output logic [5:0]            joy_raw,
    output logic                  user_osd
);
    logic [`DBX_JOY_W-1:0] sel_joy0;
    logic [`DBX_JOY_W-1:0] sel_joy1;

    // Core layout puts start on 6, coin on 7 and mode or start+B on 8
    function automatic logic [15:0] pack_joy(input logic [`DBX_JOY_W-1:0] pad);
        return {7'd0, pad[11] | (pad[10] & pad[5]), pad[9], pad[10], pad[5:0]};
    endfunction

    // ====================
    // Selection stage
    // ====================

    // DB15 wins over DB9, nothing attached gives zero words
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel_joy0 <= '0;
            sel_joy1 <= '0;
        end else if (db15_hooked) begin
            sel_joy0 <= db15_joy0;
            sel_joy1 <= db15_joy1;
        end else if (db9_hooked) begin
            sel_joy0 <= db9_joy0;
            sel_joy1 <= db9_joy1;
        end else begin
            sel_joy0 <= '0;
            sel_joy1 <= '0;
        end
    end

    // Output stage, usb words enter here so they see a single clock of delay
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            joystick_0 <= '0;
            joystick_1 <= '0;
            joy_raw    <= '0;
            user_osd   <= 1'b0;
        end else begin
            joystick_0 <= pack_joy(sel_joy0) | usb0;
            joystick_1 <= pack_joy(sel_joy1) | usb1;
            joy_raw    <= sel_joy0[5:0] | sel_joy1[5:0];
            // Start together with button 3 on player 0 opens the OSD
            user_osd   <= sel_joy0[10] & sel_joy0[6];
        end
    end

endmodule

`default_nettype wire

// File: dbxjoy_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "dbxjoy_config.svh"

// Joystick front end on the 8-pin user port, DB9 and DB15 readers take turns
module dbxjoy_top (
    input  logic        rst,
    input  logic        clk,
    input  logic [7:0]  user_in,
    input  logic [15:0] joystick_0_usb,
    input  logic [15:0] joystick_1_usb,
    output logic [15:0] joystick_0,
    output logic [15:0] joystick_1,
    output logic [5:0]  joy_raw,
    output logic        user_osd,
    output logic [7:0]  user_out
);
    import dbxjoy_pkg::*;

    logic [`DBX_CEN_BITS-1:0] cen_cnt;
    logic                     cen;
    scan_sel_t                scan;
    logic                     db9_split, db9_sel, db9_hooked, db9_sample;
    logic                     db15_loadb, db15_clk, db15_hooked, db15_sample;
    logic [`DBX_JOY_W-1:0]    db9_joy0, db9_joy1, db15_joy0, db15_joy1;
    logic [5:0]               db9_din;

    // ====================
    // Clock enable and scan
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_cnt <= '0;
            cen     <= 1'b0;
        end else begin
            cen_cnt <= cen_cnt + {{(`DBX_CEN_BITS-1){1'b0}}, 1'b1};
            cen     <= &cen_cnt;
        end
    end

    // Ownership passes over each time a reader finishes a full round
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            scan <= scan_db9;
        else if (db9_sample || db15_sample)
            scan <= (scan == scan_db9) ? scan_db15 : scan_db9;
    end

    // Pin 0 is shared, an idle reader holds its side high so the other controls it
    assign user_out = {3'b111, db9_split, 2'b11, db15_clk, db9_sel & db15_loadb};
    assign db9_din  = {user_in[6], user_in[3], user_in[5], user_in[7], user_in[1], user_in[2]};

    db9_reader u_db9 (
        .rst(rst), .clk(clk), .cen(cen), .scan_en(scan == scan_db9),
        .din(db9_din), .split(db9_split), .sel(db9_sel),
        .hooked(db9_hooked), .sample(db9_sample), .joy0(db9_joy0), .joy1(db9_joy1)
    );

    db15_reader u_db15 (
        .rst(rst), .clk(clk), .cen(cen), .scan_en(scan == scan_db15),
        .din(user_in[5]), .loadb(db15_loadb), .joy_clk(db15_clk),
        .hooked(db15_hooked), .sample(db15_sample), .joy0(db15_joy0), .joy1(db15_joy1)
    );

    joy_merge u_merge (
        .clk(clk), .rst(rst), .db9_hooked(db9_hooked), .db15_hooked(db15_hooked),
        .db9_joy0(db9_joy0), .db9_joy1(db9_joy1), .db15_joy0(db15_joy0),
        .db15_joy1(db15_joy1), .usb0(joystick_0_usb), .usb1(joystick_1_usb),
        .joystick_0(joystick_0), .joystick_1(joystick_1), .joy_raw(joy_raw),
        .user_osd(user_osd)
    );

endmodule

`default_nettype wire

// File: dbxjoy_checker.sv
`timescale 1ns/1ns
`default_nettype none

// Port and output rules watched inside dbxjoy_top
module dbxjoy_checker (
    input logic        clk,
    input logic        rst,
    input logic        loadb,
    input logic        sel,
    input logic [7:0]  user_out,
    input logic [15:0] joystick_0,
    input logic [15:0] joystick_1,
    input logic [15:0] joystick_0_usb,
    input logic [15:0] joystick_1_usb
);

    // ====================
    // Shared port
    // ====================

    // DB9 select and DB15 load share pin 0, so they never go low together
    a_pin0_shared: assert property (@(posedge clk) disable iff (rst) loadb || sel)
        else $error("loadb and sel low in the same cycle");

    // The port idles high for as long as reset holds
    a_reset_high: assert property (@(posedge clk) rst |-> (user_out == 8'hFF))
        else $error("user_out not all ones during reset");

    // Pads reach only bits 8 to 0, upper bits can come only from last cycle's usb word
    a_upper_zero: assert property (@(posedge clk) disable iff (rst)
        ((joystick_0[15:9] & ~$past(joystick_0_usb[15:9])) == 7'd0) &&
        ((joystick_1[15:9] & ~$past(joystick_1_usb[15:9])) == 7'd0))
        else $error("pad data in the upper seven joystick bits");

endmodule

`default_nettype wire

// File: dbxjoy_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "dbxjoy_config.svh"

module dbxjoy_tb;

    localparam int MODE_NONE = 0;
    localparam int MODE_DB9  = 1;
    localparam int MODE_DB15 = 2;
    localparam int MODE_BOTH = 3;
    localparam int ROWS      = 13;
    // Two full scan rounds stay well below 1000 cen periods
    localparam int SETTLE_CYC = 1000 * (1 << `DBX_CEN_BITS);
    localparam int WATCH_CYC  = 3 + ROWS * (SETTLE_CYC + 4) + 2000;

    logic        clk;
    logic        rst;
    logic [7:0]  user_in;
    logic [7:0]  user_out;
    logic [15:0] usb0;
    logic [15:0] usb1;
    logic [15:0] joystick_0;
    logic [15:0] joystick_1;
    logic [5:0]  joy_raw;
    logic        user_osd;

    // Attached hardware and the buttons each pad model holds
    logic                   db9_on;
    logic                   db15_on;
    logic [`DBX_JOY_W-1:0]  md0;
    logic [`DBX_JOY_W-1:0]  md1;
    logic [`DBX_JOY_W-1:0]  neo0;
    logic [`DBX_JOY_W-1:0]  neo1;
    logic [`DBX_NEO_BITS:0] chain = '1;
    logic [7:0]             md_side;
    logic [7:0]             neo_side;

    // ====================
    // Stimulus table
    // ====================

    int                    tab_mode [ROWS];
    logic [`DBX_JOY_W-1:0] tab_p0 [ROWS];
    logic [`DBX_JOY_W-1:0] tab_p1 [ROWS];
    logic [15:0]           tab_u0 [ROWS];
    logic [15:0]           tab_u1 [ROWS];
    logic [15:0]           exp_j0 [ROWS];
    logic [15:0]           exp_j1 [ROWS];
    logic [15:0]           exp_raw [ROWS];
    logic [15:0]           exp_osd [ROWS];
    integer                seed = 37509;
    int                    errors = 0;
    int                    checks = 0;

    dbxjoy_top DUT (
        .rst(rst),
        .clk(clk),
        .user_in(user_in),
        .joystick_0_usb(usb0),
        .joystick_1_usb(usb1),
        .joystick_0(joystick_0),
        .joystick_1(joystick_1),
        .joy_raw(joy_raw),
        .user_osd(user_osd),
        .user_out(user_out)
    );

    bind dbxjoy_top dbxjoy_checker u_checker (
        .clk(clk),
        .rst(rst),
        .loadb(db15_loadb),
        .sel(db9_sel),
        .user_out(user_out),
        .joystick_0(joystick_0),
        .joystick_1(joystick_1),
        .joystick_0_usb(joystick_0_usb),
        .joystick_1_usb(joystick_1_usb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Mega Drive pad pins, sel high gives directions with B and C
    // With sel low left and right go low while B carries A and C carries start
    function automatic logic [7:0] md_pins(input logic sel_hi, input logic [11:0] p);
        logic [7:0] pins;
        pins = 8'hFF;
        pins[6] = ~p[3];
        pins[3] = ~p[2];
        if (sel_hi) begin
            pins[5] = ~p[1];
            pins[7] = ~p[0];
            pins[1] = ~p[4];
            pins[2] = ~p[5];
        end else begin
            pins[5] = 1'b0;
            pins[7] = 1'b0;
            pins[1] = ~p[6];
            pins[2] = ~p[10];
        end
        return pins;
    endfunction

    // Split picks the pad, pins wire-AND with the Neo Geo data line on bit 5
    assign md_side  = db9_on ? md_pins(user_out[0], user_out[4] ? md1 : md0) : 8'hFF;
    assign neo_side = db15_on ? {2'b11, chain[0], 5'b11111} : 8'hFF;
    assign user_in  = md_side & neo_side;

    // Neo Geo chain loads player 0, player 1 and a low sentinel, pull-up fills behind
    always @(negedge user_out[0] or posedge user_out[1]) begin
        if (!user_out[0])
            chain <= {1'b0, ~neo1, ~neo0};
        else
            chain <= {1'b1, chain[`DBX_NEO_BITS:1]};
    end

    // Core word layout: low six pad bits, start on 6, coin on 7, mode or start+B on 8
    function automatic logic [15:0] core_word(input logic [11:0] pad, input logic [15:0] usb);
        logic [15:0] w;
        w = 16'h0000;
        w[5:0] = pad[5:0];
        w[6] = pad[10];
        w[7] = pad[9];
        w[8] = pad[11] | (pad[10] & pad[5]);
        return w | usb;
    endfunction

    function automatic logic [11:0] rand_pad();
        logic [31:0] r;
        r = $random(seed);
        return r[11:0];
    endfunction

    function automatic logic [15:0] rand_usb();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    task automatic set_row(input int idx, input int mode, input logic [11:0] p0_in,
                           input logic [11:0] p1_in, input logic [15:0] u0,
                           input logic [15:0] u1);
        logic [11:0] p0;
        logic [11:0] p1;
        p0 = p0_in;
        p1 = p1_in;
        if (mode == MODE_DB9) begin
            // Three-button pads have no coin, mode, b4 or b5
            p0 = p0 & 12'h47F;
            // Empty DB15 reads take player 1 left as the sentinel
            p1 = p1 & 12'h47D;
        end
        tab_mode[idx] = mode;
        tab_p0[idx] = p0;
        tab_p1[idx] = p1;
        tab_u0[idx] = u0;
        tab_u1[idx] = u1;
        if (mode == MODE_NONE) begin
            p0 = 12'h000;
            p1 = 12'h000;
        end
        exp_j0[idx] = core_word(p0, u0);
        exp_j1[idx] = core_word(p1, u1);
        exp_raw[idx] = {10'd0, p0[5:0] | p1[5:0]};
        exp_osd[idx] = {15'd0, p0[10] & p0[6]};
    endtask

    task automatic compare_val(input string name, input int row, input logic [15:0] exp_v,
                               input logic [15:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            errors++;
            $display("FAIL row %0d %s expected %h actual %h", row, name, exp_v, act_v);
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        rst     <= 1'b1;
        usb0    <= 16'h0000;
        usb1    <= 16'h0000;
        db9_on  <= 1'b0;
        db15_on <= 1'b0;
        md0     <= '0;
        md1     <= '0;
        neo0    <= '0;
        neo1    <= '0;
        set_row(0, MODE_NONE, 12'h000, 12'h000, 16'h0000, 16'h0000);
        set_row(1, MODE_NONE, rand_pad(), rand_pad(), 16'h8001, 16'h0240);
        set_row(2, MODE_DB9, rand_pad(), rand_pad(), 16'h0000, 16'h0000);
        set_row(3, MODE_DB9, rand_pad(), rand_pad(), 16'h0000, 16'h0000);
        // Start with A on player 0 asks for the OSD
        set_row(4, MODE_DB9, 12'h440, 12'h000, 16'h0000, 16'h0000);
        set_row(5, MODE_DB9, rand_pad(), rand_pad(), rand_usb(), rand_usb());
        set_row(6, MODE_DB15, rand_pad(), rand_pad(), 16'h0000, 16'h0000);
        set_row(7, MODE_DB15, 12'h800, 12'h420, 16'h0000, 16'h0000);
        set_row(8, MODE_DB15, 12'hFFF, 12'h000, 16'h0000, 16'h0000);
        set_row(9, MODE_DB15, rand_pad(), rand_pad(), rand_usb(), rand_usb());
        set_row(10, MODE_BOTH, rand_pad(), rand_pad(), 16'h0000, 16'h0000);
        set_row(11, MODE_BOTH, rand_pad(), rand_pad(), rand_usb(), rand_usb());
        set_row(12, MODE_NONE, 12'h000, 12'h000, 16'h0000, 16'h0000);
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < ROWS; i++) begin
            @(posedge clk);
            db9_on  <= (tab_mode[i] == MODE_DB9) || (tab_mode[i] == MODE_BOTH);
            db15_on <= (tab_mode[i] == MODE_DB15) || (tab_mode[i] == MODE_BOTH);
            // With both attached the DB9 pads hold a pattern of their own
            md0  <= (tab_mode[i] == MODE_BOTH) ? 12'h47F : tab_p0[i];
            md1  <= (tab_mode[i] == MODE_BOTH) ? 12'h47D : tab_p1[i];
            neo0 <= tab_p0[i];
            neo1 <= tab_p1[i];
            usb0 <= tab_u0[i];
            usb1 <= tab_u1[i];
            repeat (SETTLE_CYC) @(posedge clk);
            @(negedge clk);
            compare_val("joystick_0", i, exp_j0[i], joystick_0);
            compare_val("joystick_1", i, exp_j1[i], joystick_1);
            compare_val("joy_raw", i, exp_raw[i], {10'd0, joy_raw});
            compare_val("user_osd", i, exp_osd[i], {15'd0, user_osd});
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Bound follows the table length and the settle time per row
    initial begin
        repeat (WATCH_CYC) @(posedge clk);
        $display("Timeout: the table did not finish within %0d clocks", WATCH_CYC);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dbxjoy.f
+incdir+.
dbxjoy_pkg.sv
db9_reader.sv
db15_reader.sv
joy_merge.sv
dbxjoy_top.sv
dbxjoy_checker.sv
dbxjoy_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dbxjoy_tb
FILELIST  ?= dbxjoy.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: PASSED" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
